// File: flist.f
src/lsuIsaPkg.sv
src/lsuMemPkg.sv
src/memReqIf.sv
src/lsDecode.sv
src/loadStoreBuffer.sv
src/dataPort.sv
src/memCtrl.sv
src/lsResult.sv
src/lsuTop.sv
verification/lsu_chk.sv
verification/lsuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module lsuTb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: src/dataPort.sv
`timescale 1ns/10ps

module dataPort import lsuIsaPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    memReqIf.snk               req,
    input  logic [TagBits-1:0] reqTag,
    input  logic               reqSigned,
    output logic               portFree,
    memReqIf.src               mem,
    input  logic               memWait,
    input  logic               memDone,
    input  logic [XLen-1:0]    memData,
    output logic               portDone,
    output logic [XLen-1:0]    portData,
    output logic [TagBits-1:0] portTag,
    output logic               portSigned,
    output logic [LenBits-1:0] portLen
);

    logic               occupied;
    logic               doneQ;
    logic               take;
    logic               ls;
    logic               isSigned;
    logic [XLen-1:0]    addr;
    logic [XLen-1:0]    data;
    logic [LenBits-1:0] len;
    logic [TagBits-1:0] tag;

    assign portFree = !occupied;
    assign take     = rdy && portFree && req.en;
    assign portDone = doneQ && rdy;

    // Present the request only while the controller is free.
    assign mem.en   = occupied && !memWait;
    assign mem.ls   = ls;
    assign mem.addr = addr;
    assign mem.data = data;
    assign mem.len  = len;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            doneQ    <= 1'b0;
        end else if (rdy) begin
            doneQ <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
            end else if (take) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ls       <= req.ls;
            addr     <= req.addr;
            data     <= req.data;
            len      <= req.len;
            tag      <= reqTag;
            isSigned <= reqSigned;
        end
        if (rdy && memDone) begin
            portData   <= memData;
            portTag    <= tag;
            portSigned <= isSigned;
            portLen    <= len;
        end
    end

endmodule

// File: src/loadStoreBuffer.sv
`timescale 1ns/10ps

module loadStoreBuffer import lsuIsaPkg::*, lsuMemPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               pushEn,
    input  lsReqT              pushReq,
    input  logic [TagBits-1:0] pushTag,
    input  logic               pushSigned,
    output logic               full,
    memReqIf.src               head,
    output logic [TagBits-1:0] headTag,
    output logic               headSigned,
    input  logic               portFree
);

    lsReqT                 entries [BufDepth];
    logic [TagBits-1:0]    tags [BufDepth];
    logic                  signs [BufDepth];
    logic [BufPtrBits-1:0] wrPtr;
    logic [BufPtrBits-1:0] rdPtr;
    logic [BufPtrBits:0]   count;
    logic                  notEmpty;
    logic                  push;
    logic                  pop;

    assign notEmpty = (count != '0);
    assign pop      = rdy && portFree && notEmpty;
    assign push     = rdy && pushEn && ((count != (BufPtrBits+1)'(BufDepth)) || pop);

    // The decode stage holds one more request in flight.
    assign full = (count == (BufPtrBits+1)'(BufDepth))
               || ((count == (BufPtrBits+1)'(BufDepth-1)) && pushEn);

    assign head.en    = notEmpty;
    assign head.ls    = entries[rdPtr].ls;
    assign head.addr  = entries[rdPtr].addr;
    assign head.data  = entries[rdPtr].data;
    assign head.len   = entries[rdPtr].len;
    assign headTag    = tags[rdPtr];
    assign headSigned = signs[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + BufPtrBits'(1);
            end
            if (pop) begin
                rdPtr <= rdPtr + BufPtrBits'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (BufPtrBits+1)'(1);
                2'b01:   count <= count - (BufPtrBits+1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushReq;
            tags[wrPtr]    <= pushTag;
            signs[wrPtr]   <= pushSigned;
        end
    end

endmodule

// File: src/lsDecode.sv
`timescale 1ns/10ps

module lsDecode import lsuIsaPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               issueEn,
    input  opcodeT             opcode,
    input  widthT              funct3,
    input  logic [XLen-1:0]    base,
    input  logic [XLen-1:0]    storeData,
    input  logic [11:0]        offset,
    input  logic [TagBits-1:0] tag,
    input  logic               full,
    output logic               pushEn,
    output lsReqT              pushReq,
    output logic [TagBits-1:0] pushTag,
    output logic               pushSigned
);

    logic               validOp;
    logic [XLen-1:0]    effAddr;
    logic [LenBits-1:0] byteLen;

    assign validOp = (opcode == opLoad) || (opcode == opStore);
    assign effAddr = base + {{(XLen-12){offset[11]}}, offset};

    always_comb begin
        case (funct3)
            wByte, wByteU: byteLen = LenBits'(1);
            wHalf, wHalfU: byteLen = LenBits'(2);
            default:       byteLen = LenBits'(4);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pushEn <= 1'b0;
        end else if (rdy) begin
            pushEn <= issueEn && validOp && !full;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            pushReq.ls   <= (opcode == opStore);
            pushReq.addr <= effAddr;
            pushReq.data <= storeData;
            pushReq.len  <= byteLen;
            pushTag      <= tag;
            // Only signed loads extend.
            pushSigned   <= (opcode == opLoad) && ((funct3 == wByte) || (funct3 == wHalf));
        end
    end

endmodule

// File: src/lsResult.sv
`timescale 1ns/10ps

module lsResult import lsuIsaPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               portDone,
    input  logic [XLen-1:0]    portData,
    input  logic [TagBits-1:0] portTag,
    input  logic               portSigned,
    input  logic [LenBits-1:0] portLen,
    output logic               cdbValid,
    output logic [TagBits-1:0] cdbTag,
    output logic [XLen-1:0]    cdbData
);

    logic            validQ;
    logic [XLen-1:0] extData;

    // Upper bits arrive as zero, so only signed loads need work.
    always_comb begin
        extData = portData;
        if (portSigned) begin
            case (portLen)
                LenBits'(1): extData = {{(XLen-8){portData[7]}}, portData[7:0]};
                LenBits'(2): extData = {{(XLen-16){portData[15]}}, portData[15:0]};
                default:     extData = portData;
            endcase
        end
    end

    assign cdbValid = validQ && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (rdy) begin
            validQ <= portDone;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && portDone) begin
            cdbTag  <= portTag;
            cdbData <= extData;
        end
    end

endmodule

// File: src/lsuIsaPkg.sv
package lsuIsaPkg;

    localparam int XLen    = 32;
    localparam int TagBits = 4;
    localparam int LenBits = 3;

    // Major opcodes of the RV32I memory instructions.
    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,
        opStore = 7'b0100011
    } opcodeT;

    // Access width from funct3.
    typedef enum logic [2:0] {
        wByte  = 3'b000,
        wHalf  = 3'b001,
        wWord  = 3'b010,
        wByteU = 3'b100,
        wHalfU = 3'b101
    } widthT;

    // Decoded request as it sits in the queue.
    typedef struct packed {
        logic               ls;
        logic [XLen-1:0]    addr;
        logic [XLen-1:0]    data;
        logic [LenBits-1:0] len;
    } lsReqT;

endpackage

// File: src/lsuMemPkg.sv
package lsuMemPkg;

    // RAM is byte addressed and wraps at MemBytes.
    localparam int MemAddrBits = 10;
    localparam int MemBytes    = 1 << MemAddrBits;

    // Load/store queue depth.
    localparam int BufDepth   = 4;
    localparam int BufPtrBits = $clog2(BufDepth);

    // Byte lanes in one data word.
    localparam int LaneBits = 2;

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlXfer,
        ctrlDone
    } ctrlStateT;

endpackage

// File: src/lsuTop.sv
`timescale 1ns/10ps

module lsuTop import lsuIsaPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               issueEn,
    input  opcodeT             opcode,
    input  widthT              funct3,
    input  logic [XLen-1:0]    base,
    input  logic [11:0]        offset,
    input  logic [XLen-1:0]    storeData,
    input  logic [TagBits-1:0] tag,
    input  logic               fetchBusy,
    output logic               full,
    output logic               cdbValid,
    output logic [TagBits-1:0] cdbTag,
    output logic [XLen-1:0]    cdbData
);

    logic               pushEn;
    lsReqT              pushReq;
    logic [TagBits-1:0] pushTag;
    logic               pushSigned;
    logic [TagBits-1:0] headTag;
    logic               headSigned;
    logic               portFree;
    logic               memWait;
    logic               memDone;
    logic [XLen-1:0]    memData;
    logic               portDone;
    logic [XLen-1:0]    portData;
    logic [TagBits-1:0] portTag;
    logic               portSigned;
    logic [LenBits-1:0] portLen;

    memReqIf bufReq ();
    memReqIf memReq ();

    lsDecode i_lsDecode (
        .clk, .rst, .rdy, .issueEn, .opcode, .funct3, .base, .storeData, .offset, .tag,
        .full, .pushEn, .pushReq, .pushTag, .pushSigned
    );

    loadStoreBuffer i_loadStoreBuffer (
        .clk, .rst, .rdy, .pushEn, .pushReq, .pushTag, .pushSigned, .full,
        .head(bufReq.src), .headTag, .headSigned, .portFree
    );

    dataPort i_dataPort (
        .clk, .rst, .rdy, .req(bufReq.snk), .reqTag(headTag), .reqSigned(headSigned),
        .portFree, .mem(memReq.src), .memWait, .memDone, .memData,
        .portDone, .portData, .portTag, .portSigned, .portLen
    );

    memCtrl i_memCtrl (
        .clk, .rst, .rdy, .req(memReq.snk), .fetchBusy, .memWait, .memDone, .memData
    );

    lsResult i_lsResult (
        .clk, .rst, .rdy, .portDone, .portData, .portTag, .portSigned, .portLen,
        .cdbValid, .cdbTag, .cdbData
    );

endmodule

// File: src/memCtrl.sv
`timescale 1ns/10ps

module memCtrl import lsuIsaPkg::*, lsuMemPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    memReqIf.snk            req,
    input  logic            fetchBusy,
    output logic            memWait,
    output logic            memDone,
    output logic [XLen-1:0] memData
);

    logic [7:0] ram [MemBytes] = '{default: 8'h00};

    ctrlStateT              state;
    logic                   accept;
    logic [MemAddrBits-1:0] ptr;
    logic [LenBits-1:0]     left;
    logic [LaneBits-1:0]    lane;
    logic                   isStore;
    logic [XLen-1:0]        wrData;
    logic [XLen-1:0]        rdData;

    assign accept  = rdy && (state == ctrlIdle) && req.en;

    // Fetch owns the port, or a transfer is running.
    assign memWait = fetchBusy || (state != ctrlIdle);
    assign memDone = rdy && (state == ctrlDone);
    assign memData = rdData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrlIdle;
        end else if (rdy) begin
            case (state)
                ctrlIdle: begin
                    if (req.en) begin
                        state <= ctrlXfer;
                    end
                end
                ctrlXfer: begin
                    if (left == LenBits'(1)) begin
                        state <= ctrlDone;
                    end
                end
                default: begin
                    state <= ctrlIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ptr     <= req.addr[MemAddrBits-1:0];
            left    <= req.len;
            lane    <= '0;
            isStore <= req.ls;
            wrData  <= req.data;
            rdData  <= '0;
        end else if (rdy && (state == ctrlXfer)) begin
            // One byte per cycle, little-endian.
            if (isStore) begin
                ram[ptr] <= wrData[7:0];
                wrData   <= wrData >> 8;
            end else begin
                rdData[8*lane +: 8] <= ram[ptr];
            end
            ptr  <= ptr + MemAddrBits'(1);
            left <= left - LenBits'(1);
            lane <= lane + LaneBits'(1);
        end
    end

endmodule

// File: src/memReqIf.sv
`timescale 1ns/10ps

interface memReqIf import lsuIsaPkg::*; ();

    logic               en;
    logic               ls;
    logic [XLen-1:0]    addr;
    logic [XLen-1:0]    data;
    logic [LenBits-1:0] len;

    modport src (
        output en,
        output ls,
        output addr,
        output data,
        output len
    );

    modport snk (
        input en,
        input ls,
        input addr,
        input data,
        input len
    );

endinterface

// File: verification/lsuTb.sv
`timescale 1ns/10ps

module lsuTb import lsuIsaPkg::*; ();

    localparam int NumOps         = 70;
    localparam int WatchdogCycles = 200 * NumOps + 500;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic               issueEn;
    opcodeT             opcode;
    widthT              funct3;
    logic [XLen-1:0]    base;
    logic [11:0]        offset;
    logic [XLen-1:0]    storeData;
    logic [TagBits-1:0] tag;
    logic               fetchBusy;
    logic               full;
    logic               cdbValid;
    logic [TagBits-1:0] cdbTag;
    logic [XLen-1:0]    cdbData;

    logic [7:0]         refMem [1024];
    logic [TagBits-1:0] expTag [$];
    logic [XLen-1:0]    expData [$];
    logic [TagBits-1:0] nextTag;
    logic [15:0]        lfsr;
    logic               busyHold;
    logic               sawFull;

    lsuTop i_lsuTop (.*);

    bind lsuTop lsuChk i_lsuChk (
        .clk(clk), .rst(rst), .rdy(rdy), .fetchBusy(fetchBusy), .full(full),
        .cdbValid(cdbValid), .memDone(memDone), .memEn(memReq.en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] loadValue(input logic [9:0] a, input widthT w);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = refMem[a];
        b1 = refMem[a + 10'd1];
        case (w)
            wByte:   return {{24{b0[7]}}, b0};
            wByteU:  return {24'h0, b0};
            wHalf:   return {{16{b1[7]}}, b1, b0};
            wHalfU:  return {16'h0, b1, b0};
            default: return {refMem[a + 10'd3], refMem[a + 10'd2], b1, b0};
        endcase
    endfunction

    task automatic issueOp(input logic isStore, input widthT w, input logic [31:0] b,
                           input logic [11:0] off, input logic [31:0] d);
        logic [31:0] addr;
        int          len;
        addr = b + {{20{off[11]}}, off};
        len  = (w == wByte || w == wByteU) ? 1 : ((w == wHalf || w == wHalfU) ? 2 : 4);
        while (full) @(posedge clk);
        if (isStore) begin
            for (int i = 0; i < len; i++) begin
                refMem[addr[9:0] + 10'(i)] = d[8*i +: 8];
            end
            expData.push_back('0);
        end else begin
            expData.push_back(loadValue(addr[9:0], w));
        end
        expTag.push_back(nextTag);
        issueEn   <= 1'b1;
        opcode    <= isStore ? opStore : opLoad;
        funct3    <= w;
        base      <= b;
        offset    <= off;
        storeData <= d;
        tag       <= nextTag;
        rdy       <= 1'b1;
        nextTag = nextTag + 4'd1;
        @(posedge clk);
        issueEn <= 1'b0;
        @(posedge clk);
    endtask

    task automatic randomOp(input logic [31:0] b);
        widthT w;
        case (randBits(3) % 5)
            0:       w = wByte;
            1:       w = wHalf;
            2:       w = wByteU;
            3:       w = wHalfU;
            default: w = wWord;
        endcase
        issueOp(randBits(1) == 1, w, b, 12'(randBits(6)), randBits(32));
    endtask

    task automatic drain();
        while (expTag.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    // Scoreboard on the result bus.
    always @(posedge clk) begin
        if (!rst && cdbValid) begin
            if (expTag.size() == 0) begin
                $display("Unexpected result with tag %0d at time %0t", cdbTag, $time);
                abortRun();
            end else begin
                assert (!busyHold) else begin
                    $display("Fail at %0t: result appeared while fetchBusy held", $time);
                    abortRun();
                end
                assert (cdbTag == expTag[0] && cdbData == expData[0]) else begin
                    $display("Fail at %0t: got tag %0d data %h, expected tag %0d data %h",
                             $time, cdbTag, cdbData, expTag[0], expData[0]);
                    abortRun();
                end
                void'(expTag.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    // Queue back-pressure seen at the top level.
    always @(posedge clk) begin
        if (!rst && full) begin
            sawFull <= 1'b1;
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: results did not drain within %0d cycles", WatchdogCycles);
        abortRun();
    end

    initial begin
        rst       = 1'b1;
        rdy       = 1'b1;
        issueEn   = 1'b0;
        opcode    = opLoad;
        funct3    = wWord;
        base      = '0;
        offset    = '0;
        storeData = '0;
        tag       = '0;
        fetchBusy = 1'b0;
        nextTag   = '0;
        lfsr      = 16'd17866;
        busyHold  = 1'b0;
        sawFull   = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            refMem[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Word store then load back.
        issueOp(1'b1, wWord, 32'h100, 12'h000, 32'h1234_5678);
        issueOp(1'b0, wWord, 32'h100, 12'h000, 32'h0);
        // Unaligned narrow loads with sign and zero extension.
        issueOp(1'b1, wWord, 32'h200, 12'h003, 32'h80FF_7F81);
        issueOp(1'b0, wByte, 32'h203, 12'h000, 32'h0);
        issueOp(1'b0, wByteU, 32'h203, 12'h000, 32'h0);
        issueOp(1'b0, wByte, 32'h204, 12'h000, 32'h0);
        issueOp(1'b0, wByteU, 32'h204, 12'h000, 32'h0);
        issueOp(1'b0, wHalf, 32'h203, 12'h000, 32'h0);
        issueOp(1'b0, wHalfU, 32'h203, 12'h000, 32'h0);
        issueOp(1'b0, wHalf, 32'h205, 12'h000, 32'h0);
        issueOp(1'b0, wHalfU, 32'h205, 12'h000, 32'h0);
        // Address wrap at 1024 bytes and a negative offset.
        issueOp(1'b1, wWord, 32'h450, 12'h000, 32'hCAFE_F00D);
        issueOp(1'b0, wWord, 32'h050, 12'h000, 32'h0);
        issueOp(1'b1, wHalf, 32'h460, 12'hFF0, 32'h0000_9ABC);
        issueOp(1'b0, wHalf, 32'h050, 12'h000, 32'h0);
        drain();

        // Back-to-back traffic fills the queue.
        sawFull = 1'b0;
        repeat (8) randomOp(32'h300);
        drain();
        assert (sawFull) else begin
            $display("Fail at %0t: full never rose during back-to-back issue", $time);
            abortRun();
        end

        // Fetch owns the port while requests pile up.
        busyHold = 1'b1;
        fetchBusy <= 1'b1;
        repeat (4) randomOp(32'h300);
        repeat (30) @(posedge clk);
        fetchBusy <= 1'b0;
        busyHold = 1'b0;
        drain();

        // Random traffic with stall and fetch pulses.
        repeat (40) begin
            if (randBits(1) == 1) begin
                rdy <= 1'b0;
                repeat (1 + randBits(2)) @(posedge clk);
                rdy <= 1'b1;
            end
            if (randBits(2) == 0) begin
                fetchBusy <= 1'b1;
                repeat (1 + randBits(3)) @(posedge clk);
                fetchBusy <= 1'b0;
            end
            randomOp(32'h300);
        end
        drain();
        repeat (20) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verification/lsu_chk.sv
`timescale 1ns/10ps

module lsuChk (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic fetchBusy,
    input logic full,
    input logic cdbValid,
    input logic memDone,
    input logic memEn
);

    // Done strobes are single-cycle pulses.
    cdbPulse: assert property (@(posedge clk) disable iff (rst) cdbValid |=> !cdbValid)
        else $error("cdbValid high for two consecutive cycles");

    memDonePulse: assert property (@(posedge clk) disable iff (rst) memDone |=> !memDone)
        else $error("memDone high for two consecutive cycles");

    // Queue starts empty.
    fullAfterReset: assert property (@(posedge clk) $fell(rst) |-> !full [*5])
        else $error("full raised within 5 cycles of reset release");

    // Fetch owns the port.
    noAccessWhileFetch: assert property (@(posedge clk) disable iff (rst)
        !(memEn && fetchBusy))
        else $error("memory request presented while fetchBusy was high");

    noResultWhileStalled: assert property (@(posedge clk) disable iff (rst)
        !(cdbValid && !rdy))
        else $error("cdbValid high while rdy was low");

endmodule
